// File: Makefile
VERILATOR  := verilator
TOP        := tb_pipeline_core
FILELIST   := src.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: common/cpu_config_pkg.sv
package cpu_config_pkg;

  localparam int data_width = 32;
  localparam int addr_width = 32;
  localparam int inst_width = 32;
  localparam int reg_addr_width = 5;
  localparam int num_regs = 2 ** reg_addr_width;
  localparam int dmem_words = 16;
  localparam int dmem_idx_width = $clog2(dmem_words);

  typedef logic [data_width-1:0] data_t;
  typedef logic [addr_width-1:0] addr_t;
  typedef logic [inst_width-1:0] inst_t;
  typedef logic [reg_addr_width-1:0] reg_addr_t;

  // R-type view of an instruction word; I-type immediate is the low 16 bits
  typedef struct packed {
    logic [5:0] opcode;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } inst_fields_t;

  localparam logic [5:0] op_rtype = 6'h00;
  localparam logic [5:0] op_beq   = 6'h04;
  localparam logic [5:0] op_addi  = 6'h08;
  localparam logic [5:0] op_lw    = 6'h23;
  localparam logic [5:0] op_sw    = 6'h2b;

  localparam logic [5:0] funct_add = 6'h20;
  localparam logic [5:0] funct_sub = 6'h22;
  localparam logic [5:0] funct_and = 6'h24;
  localparam logic [5:0] funct_or  = 6'h25;
  localparam logic [5:0] funct_slt = 6'h2a;

  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_slt = 3'd4
  } alu_op_t;

  typedef enum logic [1:0] {
    mem_none  = 2'd0,
    mem_load  = 2'd1,
    mem_store = 2'd2
  } mem_op_t;

endpackage

// File: common/pipe_types_pkg.sv
package pipe_types_pkg;

  import cpu_config_pkg::*;

  // All-zero value of each struct is the bubble

  typedef struct packed {
    inst_t instr;
    addr_t pc;
  } if_id_t;

  typedef struct packed {
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t dest;
    data_t     rs_data;
    data_t     rt_data;
    data_t     imm;
    alu_op_t   alu_op;
    logic      alu_src;    // Second operand from immediate
    mem_op_t   mem_op;
    logic      reg_write;
    logic      branch;
    addr_t     pc_plus4;
  } id_ex_t;

  typedef struct packed {
    data_t     alu_result;
    data_t     store_data;
    reg_addr_t dest;
    mem_op_t   mem_op;
    logic      reg_write;
  } ex_mem_t;

  typedef struct packed {
    data_t     result;     // Loaded word or ALU result
    reg_addr_t dest;
    logic      reg_write;
  } mem_wb_t;

  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    data_t     data;
  } wb_port_t;

endpackage

// File: decode/decode_ctrl.sv
`timescale 1ns/1ps

module decode_ctrl (
  input  pipe_types_pkg::if_id_t  if_id,
  input  cpu_config_pkg::data_t   rs_data,
  input  cpu_config_pkg::data_t   rt_data,
  output pipe_types_pkg::id_ex_t  id_ex_next
);

  import cpu_config_pkg::*;

  inst_fields_t fields;
  data_t        imm_ext;

  assign fields  = if_id.instr;
  assign imm_ext = {{(data_width - 16){if_id.instr[15]}}, if_id.instr[15:0]};

  always_comb begin
    logic known;
    known = 1'b1;
    id_ex_next          = '0;
    id_ex_next.rs       = fields.rs;
    id_ex_next.rt       = fields.rt;
    id_ex_next.rs_data  = rs_data;
    id_ex_next.rt_data  = rt_data;
    id_ex_next.imm      = imm_ext;
    id_ex_next.pc_plus4 = if_id.pc + addr_t'(4);
    case (fields.opcode)
      op_rtype: begin
        id_ex_next.dest      = fields.rd;
        id_ex_next.reg_write = 1'b1;
        case (fields.funct)
          funct_add: id_ex_next.alu_op = alu_add;
          funct_sub: id_ex_next.alu_op = alu_sub;
          funct_and: id_ex_next.alu_op = alu_and;
          funct_or:  id_ex_next.alu_op = alu_or;
          funct_slt: id_ex_next.alu_op = alu_slt;
          default:   known = 1'b0;   // Includes the all-zero word
        endcase
      end
      op_addi: begin
        id_ex_next.dest      = fields.rt;
        id_ex_next.alu_op    = alu_add;
        id_ex_next.alu_src   = 1'b1;
        id_ex_next.reg_write = 1'b1;
      end
      op_lw: begin
        id_ex_next.dest      = fields.rt;
        id_ex_next.alu_op    = alu_add;
        id_ex_next.alu_src   = 1'b1;
        id_ex_next.mem_op    = mem_load;
        id_ex_next.reg_write = 1'b1;
      end
      op_sw: begin
        id_ex_next.alu_op  = alu_add;
        id_ex_next.alu_src = 1'b1;
        id_ex_next.mem_op  = mem_store;
      end
      op_beq: begin
        id_ex_next.alu_op = alu_sub;
        id_ex_next.branch = 1'b1;
      end
      default: known = 1'b0;
    endcase
    if (!known) begin
      id_ex_next = '0;
    end
  end

endmodule

// File: execute/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
  input  pipe_types_pkg::id_ex_t   id_ex,
  input  pipe_types_pkg::ex_mem_t  ex_mem,
  input  pipe_types_pkg::wb_port_t wb,
  output pipe_types_pkg::ex_mem_t  ex_mem_next,
  output logic                     branch_taken,
  output cpu_config_pkg::addr_t    branch_target
);

  import cpu_config_pkg::*;
  import pipe_types_pkg::*;

  data_t fwd_rs;
  data_t fwd_rt;
  data_t alu_b;
  data_t alu_result;

  // Youngest producer first; a load in ex_mem never matches thanks to the load-use stall
  function automatic data_t forward(reg_addr_t src, data_t reg_val, ex_mem_t em,
                                    wb_port_t w);
    if (src == '0) begin
      return reg_val;
    end else if (em.reg_write && em.mem_op != mem_load && em.dest == src) begin
      return em.alu_result;
    end else if (w.we && w.addr == src) begin
      return w.data;
    end
    return reg_val;
  endfunction

  assign fwd_rs = forward(id_ex.rs, id_ex.rs_data, ex_mem, wb);
  assign fwd_rt = forward(id_ex.rt, id_ex.rt_data, ex_mem, wb);
  assign alu_b  = id_ex.alu_src ? id_ex.imm : fwd_rt;

  always_comb begin
    case (id_ex.alu_op)
      alu_add: alu_result = fwd_rs + alu_b;
      alu_sub: alu_result = fwd_rs - alu_b;
      alu_and: alu_result = fwd_rs & alu_b;
      alu_or:  alu_result = fwd_rs | alu_b;
      alu_slt: alu_result = data_t'($signed(fwd_rs) < $signed(alu_b));
      default: alu_result = '0;
    endcase
  end

  assign branch_taken  = id_ex.branch && (fwd_rs == fwd_rt);
  assign branch_target = id_ex.pc_plus4 + {id_ex.imm[addr_width-3:0], 2'b00};

  assign ex_mem_next = '{
    alu_result: alu_result,
    store_data: fwd_rt,
    dest:       id_ex.dest,
    mem_op:     id_ex.mem_op,
    reg_write:  id_ex.reg_write
  };

endmodule

// File: logic/data_mem.sv
`timescale 1ns/1ps

module data_mem (
  input  logic                    clk,
  input  logic                    reset,
  input  pipe_types_pkg::ex_mem_t ex_mem,
  output cpu_config_pkg::data_t   load_data
);

  import cpu_config_pkg::*;

  data_t                     mem [dmem_words];
  logic [dmem_idx_width-1:0] word_idx;

  // Byte address from the ALU, one word per entry
  assign word_idx = ex_mem.alu_result[dmem_idx_width+1:2];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < dmem_words; i++) begin
        mem[i] <= '0;
      end
    end else if (ex_mem.mem_op == mem_store) begin
      mem[word_idx] <= ex_mem.store_data;
    end
  end

  assign load_data = mem[word_idx];

  a_addr_in_range: assert property (
    @(posedge clk) disable iff (reset)
    (ex_mem.mem_op != mem_none) |-> ((ex_mem.alu_result >> 2) < dmem_words)
  );

endmodule

// File: logic/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
  input  pipe_types_pkg::id_ex_t    id_ex,
  input  cpu_config_pkg::reg_addr_t if_id_rs,
  input  cpu_config_pkg::reg_addr_t if_id_rt,
  input  logic                      branch_taken,
  input  logic                      freeze,
  output logic                      pc_stall,
  output logic                      if_id_stall,
  output logic                      if_id_flush,
  output logic                      id_ex_flush,
  output logic                      back_stall,
  output logic                      wb_nop
);

  import cpu_config_pkg::*;

  logic load_use;

  assign load_use = (id_ex.mem_op == mem_load) && (id_ex.dest != '0) &&
                    ((id_ex.dest == if_id_rs) || (id_ex.dest == if_id_rt));

  assign pc_stall    = load_use | freeze;
  assign if_id_stall = load_use | freeze;
  assign if_id_flush = branch_taken & ~freeze;
  assign id_ex_flush = (branch_taken | load_use) & ~freeze;  // Bubble on load-use
  assign back_stall  = freeze;
  assign wb_nop      = freeze;

  // Only one instruction sits in execute, so a load and a taken beq cannot meet
  always_comb begin
    if (!$isunknown({freeze, pc_stall, if_id_flush})) begin
      a_stall_flush_excl: assert (freeze || !(pc_stall && if_id_flush));
    end
  end

endmodule

// File: logic/pipe_stage_reg.sv
`timescale 1ns/1ps

module pipe_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     stall,
  input  logic     flush,
  input  logic     nop,
  input  payload_t d,
  output payload_t q
);

  payload_t data;
  logic     nop_latch;

  always_ff @(posedge clk) begin
    if (reset) begin
      data      <= '0;
      nop_latch <= 1'b0;
    end else begin
      nop_latch <= nop;
      if (flush) begin
        data <= '0;            // Flush wins over stall
      end else if (!stall) begin
        data <= d;
      end
    end
  end

  // Masked for one cycle after a nop request, the stored value is kept
  assign q = nop_latch ? '0 : data;

  a_nop_masks_output: assert property (
    @(posedge clk) disable iff (reset)
    nop |=> (q == '0)
  );

endmodule

// File: logic/pipeline_core.sv
`timescale 1ns/1ps

module pipeline_core (
  input  logic                     clk,
  input  logic                     reset,
  input  cpu_config_pkg::inst_t    imem_data,
  input  logic                     freeze,
  output cpu_config_pkg::addr_t    imem_addr,
  output pipe_types_pkg::wb_port_t wb
);

  import cpu_config_pkg::*;
  import pipe_types_pkg::*;

  addr_t        pc;
  if_id_t       if_id_next;
  if_id_t       if_id;
  id_ex_t       id_ex_next;
  id_ex_t       id_ex;
  ex_mem_t      ex_mem_next;
  ex_mem_t      ex_mem;
  mem_wb_t      mem_wb_next;
  mem_wb_t      mem_wb;
  inst_fields_t if_id_fields;
  data_t        rs_data;
  data_t        rt_data;
  data_t        load_data;
  logic         branch_taken;
  addr_t        branch_target;
  logic         pc_stall;
  logic         if_id_stall;
  logic         if_id_flush;
  logic         id_ex_flush;
  logic         back_stall;
  logic         wb_nop;
  logic         wb_masked;
  wb_port_t     wb_hold;
  wb_port_t     ex_wb;

  assign imem_addr = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (if_id_flush) begin
      pc <= branch_target;            // Taken beq leaving execute
    end else if (!pc_stall) begin
      pc <= pc + addr_t'(4);
    end
  end

  // While wb is masked by freeze, execute still needs the last written value
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_masked <= 1'b0;
      wb_hold   <= '0;
    end else begin
      wb_masked <= wb_nop;
      if (!wb_masked) begin
        wb_hold <= wb;
      end
    end
  end

  assign ex_wb = wb_masked ? wb_hold : wb;

  assign if_id_next   = '{instr: imem_data, pc: pc};
  assign if_id_fields = if_id.instr;

  pipe_stage_reg #(.payload_t(if_id_t)) u_if_id (
    .clk(clk), .reset(reset), .stall(if_id_stall), .flush(if_id_flush),
    .nop(1'b0), .d(if_id_next), .q(if_id)
  );

  reg_file u_reg_file (
    .clk(clk), .reset(reset), .rs_addr(if_id_fields.rs), .rt_addr(if_id_fields.rt),
    .wb(wb), .rs_data(rs_data), .rt_data(rt_data)
  );

  decode_ctrl u_decode (
    .if_id(if_id), .rs_data(rs_data), .rt_data(rt_data), .id_ex_next(id_ex_next)
  );

  hazard_unit u_hazard (
    .id_ex(id_ex), .if_id_rs(if_id_fields.rs), .if_id_rt(if_id_fields.rt),
    .branch_taken(branch_taken), .freeze(freeze),
    .pc_stall(pc_stall), .if_id_stall(if_id_stall), .if_id_flush(if_id_flush),
    .id_ex_flush(id_ex_flush), .back_stall(back_stall), .wb_nop(wb_nop)
  );

  pipe_stage_reg #(.payload_t(id_ex_t)) u_id_ex (
    .clk(clk), .reset(reset), .stall(back_stall), .flush(id_ex_flush),
    .nop(1'b0), .d(id_ex_next), .q(id_ex)
  );

  execute_unit u_execute (
    .id_ex(id_ex), .ex_mem(ex_mem), .wb(ex_wb), .ex_mem_next(ex_mem_next),
    .branch_taken(branch_taken), .branch_target(branch_target)
  );

  pipe_stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
    .clk(clk), .reset(reset), .stall(back_stall), .flush(1'b0),
    .nop(1'b0), .d(ex_mem_next), .q(ex_mem)
  );

  data_mem u_data_mem (
    .clk(clk), .reset(reset), .ex_mem(ex_mem), .load_data(load_data)
  );

  assign mem_wb_next = '{
    result:    (ex_mem.mem_op == mem_load) ? load_data : ex_mem.alu_result,
    dest:      ex_mem.dest,
    reg_write: ex_mem.reg_write
  };

  // nop keeps a held instruction from being written back twice
  pipe_stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
    .clk(clk), .reset(reset), .stall(back_stall), .flush(1'b0),
    .nop(wb_nop), .d(mem_wb_next), .q(mem_wb)
  );

  assign wb = '{
    we:   mem_wb.reg_write && (mem_wb.dest != '0),
    addr: mem_wb.dest,
    data: mem_wb.result
  };

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                      clk,
  input  logic                      reset,
  input  cpu_config_pkg::reg_addr_t rs_addr,
  input  cpu_config_pkg::reg_addr_t rt_addr,
  input  pipe_types_pkg::wb_port_t  wb,
  output cpu_config_pkg::data_t     rs_data,
  output cpu_config_pkg::data_t     rt_data
);

  import cpu_config_pkg::*;

  data_t regs [num_regs];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.we && wb.addr != '0) begin
      regs[wb.addr] <= wb.data;
    end
  end

  // Same-cycle write is visible to decode
  assign rs_data = (rs_addr == '0) ? '0 :
                   (wb.we && wb.addr == rs_addr) ? wb.data : regs[rs_addr];
  assign rt_data = (rt_addr == '0) ? '0 :
                   (wb.we && wb.addr == rt_addr) ? wb.data : regs[rt_addr];

endmodule

// File: src.f
common/cpu_config_pkg.sv
common/pipe_types_pkg.sv
logic/pipe_stage_reg.sv
logic/reg_file.sv
decode/decode_ctrl.sv
execute/execute_unit.sv
logic/hazard_unit.sv
logic/data_mem.sv
logic/pipeline_core.sv
test/tb_pipeline_core.sv

// File: test/program_stimulus.txt
// Header at 00: program words, freeze windows, max freeze window length, expected writebacks
// Program at 10: instruction words in fetch order, four per line
// Expected at 40: destination register and written value, two pairs per line
@00
0000001b 00000004 00000004 00000010
@10
20010005 20020003 00221820 00612022  // addi r1,5  addi r2,3  add r3  sub r4
00642824 00643025 0083382a 0064402a  // and r5  or r6  slt r7  slt r8
2009fffe 0121502a ac030008 8c0b0008  // addi r9,-2  slt r10  sw r3,8  lw r11,8
01616020 20000007 10220002 200d0001  // add r12 after load  addi r0  beq not taken  addi r13
10820002 200e0063 200f0063 218e0002  // beq taken  two skipped  addi r14,r12,2
ac0c000c 8c0f000c 11ec0002 20100001  // sw r12,12  lw r15,12  beq on loaded r15  skipped
20110001 01ee9020 1000ffff           // skipped  add r18  beq r0,r0 self-loop
@40
01 00000005  02 00000003
03 00000008  04 00000003
05 00000000  06 0000000b
07 00000001  08 00000000
09 fffffffe  0a 00000001
0b 00000008  0c 0000000d
0d 00000001  0e 0000000f
0f 0000000d  12 0000001c

// File: test/tb_pipeline_core.sv
`timescale 1ns/1ps

module tb_pipeline_core;

  import cpu_config_pkg::*;
  import pipe_types_pkg::*;

  localparam int imem_words   = 64;
  localparam int prog_base    = 16;
  localparam int expect_base  = 64;
  localparam int max_expect   = 32;
  localparam int run_timeout  = 2000;
  localparam int quiet_cycles = 20;

  logic     clk = 1'b0;
  logic     reset;
  logic     freeze;
  inst_t    imem_data;
  addr_t    imem_addr;
  wb_port_t wb;

  logic [31:0] stim [0:127];
  inst_t       imem [imem_words];
  int          prog_len;
  int          window_count;
  int          max_window;
  int          expect_count;
  int          expect_idx = 0;
  int          mismatches = 0;
  int          cycle_count = 0;
  int          seed;
  logic        freeze_seen = 1'b0;
  logic        reset_seen = 1'b1;

  pipeline_core u_dut (
    .clk(clk), .reset(reset), .imem_data(imem_data), .freeze(freeze),
    .imem_addr(imem_addr), .wb(wb)
  );

  always #2 clk = ~clk;

  // Zero words past the program decode to bubbles
  assign imem_data = (imem_addr < addr_t'(imem_words * 4)) ? imem[imem_addr[7:2]] : '0;

  task automatic end_run(input bit failed);
    if (failed) begin
      $display("STATUS: FAIL");
      $fatal(1, "run stopped, %0d mismatches", mismatches);
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      mismatches++;
      $display("** Error: time %0t, %s is %h, expected %h", $time, what, actual, expected);
      end_run(1'b1);
    end
  endtask

  task automatic drive_freeze_windows();
    int gap;
    int len;
    for (int w = 0; w < window_count; w++) begin
      gap = 2 + int'($unsigned($random(seed)) % 6);
      len = 1 + int'($unsigned($random(seed)) % max_window);
      repeat (gap) @(negedge clk);
      freeze = 1'b1;
      repeat (len) @(negedge clk);
      freeze = 1'b0;
    end
  endtask

  task automatic wait_for_writebacks();
    int waited;
    waited = 0;
    while (expect_idx < expect_count && waited < run_timeout) begin
      @(posedge clk);
      waited++;
    end
    if (expect_idx < expect_count) begin
      $display("Timeout: %0d of %0d writebacks seen after %0d cycles",
               expect_idx, expect_count, waited);
      end_run(1'b1);
    end
  endtask

  // What the DUT sampled at the last rising edge
  always @(posedge clk) begin
    freeze_seen <= freeze;
    reset_seen  <= reset;
    cycle_count <= cycle_count + 1;
  end

  always @(negedge clk) begin
    if (cycle_count > 0) begin
      if (reset_seen) begin
        check_value("wb.we in reset", 32'(wb.we), 32'd0);
        check_value("imem_addr in reset", imem_addr, 32'd0);
      end else if (freeze_seen) begin
        check_value("wb.we while held", 32'(wb.we), 32'd0);
      end else if (wb.we) begin
        if (expect_idx >= expect_count) begin
          $display("Unexpected writeback to r%0d after the expected list", wb.addr);
          end_run(1'b1);
        end else begin
          check_value("wb.addr", 32'(wb.addr), stim[expect_base + 2 * expect_idx]);
          check_value("wb.data", wb.data, stim[expect_base + 2 * expect_idx + 1]);
          expect_idx++;
        end
      end
    end
  end

  initial begin
    seed   = 32'hb096a921;
    reset  = 1'b1;
    freeze = 1'b0;
    for (int i = 0; i < imem_words; i++) begin
      imem[i] = '0;
    end
    $readmemh("test/program_stimulus.txt", stim);
    prog_len     = stim[0];
    window_count = stim[1];
    max_window   = stim[2];
    expect_count = stim[3];
    if (prog_len > imem_words || expect_count > max_expect || expect_count < 1 ||
        max_window < 1) begin
      $display("Stimulus file is missing or holds counts outside the testbench limits");
      end_run(1'b1);
    end
    for (int i = 0; i < prog_len; i++) begin
      imem[i] = stim[prog_base + i];
    end
    repeat (10) @(negedge clk);
    reset = 1'b0;
    drive_freeze_windows();
    wait_for_writebacks();
    repeat (quiet_cycles) @(posedge clk);   // Self-loop must stay silent
    end_run(mismatches != 0);
  end

endmodule
